// File: filelist.f
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_cmd_ctrl.sv
hw/uart_cmd_bridge.sv
test/uart_device_model.sv
test/tb_uart_cmd_bridge.sv

// File: hw/uart_cmd_bridge.sv
module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT       = 434,
  parameter int GAP_BITS           = 4,
  parameter int REPLY_TIMEOUT_BITS = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  input  logic            rx,
  output logic            tx,
  output logic            read_rdy,
  output uart_pkg::byte_t read_data,
  output logic            read_err
);
  import uart_pkg::*;

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_done;
  logic  rx_valid;
  byte_t rx_byte;
  logic  rx_err;

  uart_cmd_ctrl #(
    .CLKS_PER_BIT       (CLKS_PER_BIT),
    .GAP_BITS           (GAP_BITS),
    .REPLY_TIMEOUT_BITS (REPLY_TIMEOUT_BITS)
  ) u_uart_cmd_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  // the receiver runs all the time, the sequencer decides when it matters
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_err   (rx_err)
  );

endmodule

// File: hw/uart_cmd_ctrl.sv
module uart_cmd_ctrl #(
  parameter int CLKS_PER_BIT       = 434,
  parameter int GAP_BITS           = 4,
  parameter int REPLY_TIMEOUT_BITS = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  output logic            tx_start,
  output uart_pkg::byte_t tx_byte,
  input  logic            tx_done,
  input  logic            rx_valid,
  input  uart_pkg::byte_t rx_byte,
  input  logic            rx_err,
  output logic            read_rdy,
  output uart_pkg::byte_t read_data,
  output logic            read_err
);
  import uart_pkg::*;

  localparam int GAP_CYC = GAP_BITS * CLKS_PER_BIT;
  localparam int TMO_CYC = REPLY_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int CNT_MAX = (GAP_CYC > TMO_CYC) ? GAP_CYC : TMO_CYC;
  localparam int CNT_W = $clog2(CNT_MAX + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_WAIT
  } state_t;

  state_t           state_q;
  state_t           state_d;
  cmd_t             cmd_q;
  logic [CNT_W-1:0] cnt_q;
  logic             accept;
  logic             is_write;
  logic             gap_end;
  logic             reply;
  logic             timeout;

  assign accept = cmd_vld && cmd_rdy;
  assign is_write = cmd_q[CMD_RW_BIT];

  // tx_start is registered, so the gap ends one count early
  assign gap_end = (state_q == S_GAP) && (cnt_q == CNT_W'(GAP_CYC - 2));
  assign reply = (state_q == S_WAIT) && rx_valid;
  assign timeout = (state_q == S_WAIT) && !rx_valid && (cnt_q == CNT_W'(TMO_CYC - 1));

  // upper byte goes out first, lower byte only on a write
  assign tx_byte = (state_q == S_SEND_LO) ? cmd_q[0 +: DATA_BITS] : cmd_q[DATA_BITS +: DATA_BITS];

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
      begin
        if (accept)
          state_d = S_SEND_HI;
      end
      S_SEND_HI:
      begin
        if (tx_done)
          state_d = is_write ? S_GAP : S_WAIT;
      end
      S_GAP:
      begin
        if (gap_end)
          state_d = S_SEND_LO;
      end
      S_SEND_LO:
      begin
        if (tx_done)
          state_d = S_IDLE;
      end
      S_WAIT:
      begin
        if (reply || timeout)
          state_d = S_IDLE;
      end
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (reply)
      read_data <= rx_byte;
    else if (timeout)
      read_data <= '0;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= S_IDLE;
      cnt_q    <= '0;
      cmd_rdy  <= 1'b0;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      cmd_rdy  <= (state_d == S_IDLE);
      tx_start <= accept || gap_end;
      read_rdy <= reply || timeout;
      read_err <= timeout || (reply && rx_err);
      // one counter serves both the write gap and the reply timeout
      if (state_q == S_GAP || state_q == S_WAIT)
        cnt_q <= cnt_q + 1'b1;
      else
        cnt_q <= '0;
    end
  end

endmodule

// File: hw/uart_pkg.sv
package uart_pkg;

  // frame layout: start, data lsb first, even parity, stop
  localparam int DATA_BITS = 8;
  localparam int FRAME_BITS = 11;

  // bit 15 high means write, low means read
  localparam int CMD_RW_BIT = 15;

  typedef logic [DATA_BITS-1:0] byte_t;

  // host command, upper byte goes out first
  typedef logic [2*DATA_BITS-1:0] cmd_t;

endpackage

// File: hw/uart_rx.sv
module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx,
  output logic            rx_valid,
  output uart_pkg::byte_t rx_byte,
  output logic            rx_err
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int BIT_W = $clog2(DATA_BITS + 1);
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  rx_state_t        state_q;
  logic [1:0]       sync_q;
  logic             rx_s;
  logic             rx_last_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [BIT_W-1:0] bit_cnt_q;
  byte_t            shift_q;
  logic             parity_q;
  logic             fall;
  logic             half_hit;
  logic             mid_hit;

  assign rx_s = sync_q[1];
  assign fall = rx_last_q && !rx_s;
  assign half_hit = clk_cnt_q == CNT_W'(HALF_BIT - 1);
  assign mid_hit = clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1);
  assign rx_byte = shift_q;

  // two flops into the clock domain, plus one more for edge detect
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q    <= 2'b11;
      rx_last_q <= 1'b1;
    end
    else
    begin
      sync_q    <= {sync_q[0], rx};
      rx_last_q <= rx_s;
    end
  end

  // lsb arrives first
  always_ff @(posedge clk)
  begin
    if (state_q == RX_DATA && mid_hit)
      shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
    if (state_q == RX_PARITY && mid_hit)
      parity_q <= rx_s;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      rx_valid  <= 1'b0;
      rx_err    <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      case (state_q)
        RX_IDLE:
        begin
          clk_cnt_q <= '0;
          if (fall)
            state_q <= RX_START;
        end
        RX_START:
        begin
          if (half_hit)
          begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            // a glitch that is gone by half a bit is not a start bit
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
          else
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
        RX_DATA:
        begin
          if (mid_hit)
          begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == BIT_W'(DATA_BITS - 1))
              state_q <= RX_PARITY;
          end
          else
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
        RX_PARITY:
        begin
          if (mid_hit)
          begin
            clk_cnt_q <= '0;
            state_q   <= RX_STOP;
          end
          else
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
        RX_STOP:
        begin
          if (mid_hit)
          begin
            state_q  <= RX_IDLE;
            rx_valid <= 1'b1;
            // even parity over data and parity bit, stop must be high
            rx_err   <= (^shift_q ^ parity_q) | !rx_s;
          end
          else
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
        default:
          state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

// File: hw/uart_tx.sv
module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            tx_start,
  input  uart_pkg::byte_t tx_byte,
  output logic            tx_done,
  output logic            tx
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int BIT_W = $clog2(FRAME_BITS + 1);

  logic                  busy_q;
  logic [CNT_W-1:0]      clk_cnt_q;
  logic [BIT_W-1:0]      bit_cnt_q;
  logic [FRAME_BITS-2:0] shift_q;
  logic                  load;
  logic                  bit_end;

  assign load = tx_start && !busy_q;
  assign bit_end = busy_q && (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  // last cycle of the stop bit
  assign tx_done = bit_end && (bit_cnt_q == BIT_W'(FRAME_BITS - 1));

  // data, parity and stop wait here behind the start bit
  always_ff @(posedge clk)
  begin
    if (load)
      shift_q <= {1'b1, ^tx_byte, tx_byte};
    else if (bit_end)
      shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q    <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      tx        <= 1'b1;
    end
    else if (load)
    begin
      busy_q    <= 1'b1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      // start bit
      tx        <= 1'b0;
    end
    else if (busy_q)
    begin
      if (bit_end)
      begin
        clk_cnt_q <= '0;
        if (tx_done)
        begin
          busy_q <= 1'b0;
          tx     <= 1'b1;
        end
        else
        begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          tx        <= shift_q[0];
        end
      end
      else
      begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module tb_uart_cmd_bridge \
  -f filelist.f \
  -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "simulation failed"; exit 1; }

// File: test/tb_uart_cmd_bridge.sv
module tb_uart_cmd_bridge;
  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;

  localparam int B = 8;
  localparam int GAP = 4;
  localparam int TMO = 32;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  logic       read_rdy;
  byte_t      read_data;
  logic       read_err;
  byte_t      reply_byte;
  logic [1:0] reply_mode;
  int         reply_delay;
  logic       frame_vld;
  byte_t      frame_byte;
  logic       frame_bad;

  cmd_t  vec_cmd[$];
  byte_t vec_reply[$];
  int    vec_mode[$];
  byte_t frame_q[$];
  int    frame_cyc_q[$];
  int    cycle;
  int    cycle_limit;
  int    acc_cnt;
  int    rdy_cnt;

  uart_cmd_bridge #(
    .CLKS_PER_BIT       (B),
    .GAP_BITS           (GAP),
    .REPLY_TIMEOUT_BITS (TMO)
  ) u_uart_cmd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_device_model #(
    .CLKS_PER_BIT (B)
  ) u_device (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx          (tx),
    .rx          (rx),
    .reply_byte  (reply_byte),
    .reply_mode  (reply_mode),
    .reply_delay (reply_delay),
    .frame_vld   (frame_vld),
    .frame_byte  (frame_byte),
    .frame_bad   (frame_bad)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(string name, byte_t exp, byte_t act);
    if (exp !== act)
      stop_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_read(string name, byte_t exp, byte_t act);
    if (exp !== act)
      stop_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act)
      stop_run($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  // one clock edge and everything the host side sees at it
  task automatic step();
    @(posedge clk);
    cycle++;
    if (cycle > cycle_limit)
      stop_run("timeout: the run went past its cycle limit");
    if (frame_vld)
    begin
      if (frame_bad)
        stop_run("device model saw a frame on tx with bad parity or a low stop bit");
      frame_q.push_back(frame_byte);
      frame_cyc_q.push_back(cycle);
    end
    if (read_rdy)
      rdy_cnt++;
    if (rst_n && cmd_vld && cmd_rdy)
      acc_cnt++;
  endtask

  task automatic load_vectors();
    int    fd;
    string line;
    int    c;
    int    r;
    int    m;
    fd = $fopen("test/uart_cmd_vectors.txt", "r");
    if (fd == 0)
      stop_run("could not open the vector file");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == 8'h23)
        continue;
      if ($sscanf(line, "%h %h %d", c, r, m) == 3)
      begin
        vec_cmd.push_back(cmd_t'(c));
        vec_reply.push_back(byte_t'(r));
        vec_mode.push_back(m);
      end
    end
    $fclose(fd);
    if (vec_cmd.size() == 0)
      stop_run("the vector file holds no vectors");
  endtask

  initial
  begin
    int    idle;
    int    n;
    logic  held;
    logic  is_write;
    logic  done;
    logic  got_err;
    byte_t got_data;
    int    rd_cyc;
    int    gap;
    rst_n       <= 1'b0;
    cmd_in      <= '0;
    cmd_vld     <= 1'b0;
    reply_byte  <= '0;
    reply_mode  <= 2'd0;
    reply_delay <= 0;
    cycle = 0;
    acc_cnt = 0;
    rdy_cnt = 0;
    cycle_limit = 1000000;
    void'($urandom(32'h6d59));
    load_vectors();
    n = vec_cmd.size();
    // two frames, gap, worst reply delay and the full timeout per command
    cycle_limit = n * ((2 * FRAME_BITS + GAP + 10 + TMO) * B + 5) + 20 * B + 500;

    // the first edge puts the DUT into reset
    step();
    repeat (7)
    begin
      step();
      check_flag("cmd_rdy in reset", 1'b0, cmd_rdy);
      check_flag("read_rdy in reset", 1'b0, read_rdy);
      check_flag("read_err in reset", 1'b0, read_err);
      check_flag("tx in reset", 1'b1, tx);
    end
    rst_n <= 1'b1;
    step();
    step();
    check_flag("cmd_rdy after reset", 1'b1, cmd_rdy);

    held = 1'b0;
    idle = $urandom % 6;
    for (int i = 0; i < n; i++)
    begin
      if (!held)
      begin
        repeat (idle) step();
        cmd_in  <= vec_cmd[i];
        cmd_vld <= 1'b1;
      end
      while (acc_cnt == 0)
        step();
      acc_cnt--;
      reply_byte  <= vec_reply[i];
      reply_mode  <= 2'(vec_mode[i]);
      reply_delay <= $urandom % 11;
      is_write = vec_cmd[i][CMD_RW_BIT];

      // idle 0 keeps cmd_vld high into the next command
      held = 1'b0;
      if (i + 1 < n)
      begin
        idle = $urandom % 6;
        held = (idle == 0);
      end
      if (held)
        cmd_in <= vec_cmd[i+1];
      else
        cmd_vld <= 1'b0;

      done = 1'b0;
      got_err = 1'b0;
      got_data = '0;
      rd_cyc = 0;
      while (!done)
      begin
        step();
        if (is_write)
        begin
          check_flag("read_rdy during write", 1'b0, read_rdy);
          done = cmd_rdy;
        end
        else if (read_rdy)
        begin
          done = 1'b1;
          got_data = read_data;
          got_err = read_err;
          rd_cyc = cycle;
          check_flag("cmd_rdy with read_rdy", 1'b1, cmd_rdy);
        end
        else
          check_flag("cmd_rdy during read", 1'b0, cmd_rdy);
        if (!done)
          check_flag("second accept in flight", 1'b0, acc_cnt != 0);
      end

      if (is_write)
      begin
        check_flag("read_rdy pulse on a write", 1'b0, rdy_cnt != 0);
        check_flag("two write frames", 1'b1, frame_q.size() == 2);
        check_byte("tx upper byte", vec_cmd[i][15:8], frame_q[0]);
        check_byte("tx lower byte", vec_cmd[i][7:0], frame_q[1]);
        gap = frame_cyc_q[1] - frame_cyc_q[0] - FRAME_BITS * B;
        check_flag($sformatf("write gap of %0d cycles", gap), 1'b1, gap == GAP * B);
      end
      else
      begin
        check_flag("one read_rdy pulse", 1'b1, rdy_cnt == 1);
        check_flag("one read frame", 1'b1, frame_q.size() == 1);
        check_byte("tx read byte", vec_cmd[i][15:8], frame_q[0]);
        check_flag("read_err", vec_mode[i] != 0, got_err);
        if (vec_mode[i] == 0)
          check_read("read_data", vec_reply[i], got_data);
        if (vec_mode[i] == 2)
        begin
          check_read("read_data", 8'h00, got_data);
          // frame seen at mid stop, so its end lies half a bit later
          check_flag("reply timeout length", 1'b1,
            rd_cyc - (frame_cyc_q[0] + B / 2 - 2) >= TMO * B);
        end
      end
      frame_q.delete();
      frame_cyc_q.delete();
      rdy_cnt = 0;
    end

    repeat (20 * B) step();
    check_flag("stray frame on tx", 1'b0, frame_q.size() != 0);
    check_flag("stray read_rdy", 1'b0, rdy_cnt != 0);
    check_flag("cmd_rdy when idle", 1'b1, cmd_rdy);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: test/uart_cmd_vectors.txt
# command word (hex), reply byte (hex), reply mode (0 normal, 1 bad parity, 2 no reply)
# bit 15 of the command set means write, reply is ignored for writes
8012 00 0
a5c3 00 0
0034 5a 0
7f00 c3 0
1200 ff 1
0a00 00 2
ffff 00 0
0001 81 0
c07f 00 0
5500 00 1
3300 3c 0
9a9a 00 0
6100 00 2
fe01 00 0
0100 00 0
4400 7e 0
8000 00 0
2200 a5 1

// File: test/uart_device_model.sv
module uart_device_model #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            tx,
  output logic            rx,
  input  uart_pkg::byte_t reply_byte,
  input  logic [1:0]      reply_mode,
  input  int              reply_delay,
  output logic            frame_vld,
  output uart_pkg::byte_t frame_byte,
  output logic            frame_bad
);
  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;

  // idle, then an optional delay, then one frame on rx
  task automatic send_reply();
    logic [FRAME_BITS-1:0] bits;
    begin
      bits = {1'b1, (^reply_byte) ^ (reply_mode == 2'd1), reply_byte, 1'b0};
      repeat (CLKS_PER_BIT / 2) @(posedge clk);
      repeat (reply_delay * CLKS_PER_BIT) @(posedge clk);
      // mode 2 stays silent so the bridge times out
      if (reply_mode != 2'd2)
      begin
        for (int i = 0; i < FRAME_BITS; i++)
        begin
          rx <= bits[i];
          repeat (CLKS_PER_BIT) @(posedge clk);
        end
        rx <= 1'b1;
      end
    end
  endtask

  initial
  begin
    byte_t data;
    logic  start_ok;
    logic  par;
    logic  stop;
    logic  expect_lower;
    rx         <= 1'b1;
    frame_vld  <= 1'b0;
    frame_bad  <= 1'b0;
    frame_byte <= '0;
    expect_lower = 1'b0;
    forever
    begin
      @(posedge clk);
      if (rst_n && !tx)
      begin
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        start_ok = !tx;
        for (int i = 0; i < DATA_BITS; i++)
        begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          data[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        par = tx;
        repeat (CLKS_PER_BIT) @(posedge clk);
        stop = tx;
        frame_byte <= data;
        frame_bad  <= !start_ok || ((^data) != par) || !stop;
        frame_vld  <= 1'b1;
        @(posedge clk);
        frame_vld <= 1'b0;
        // a write upper byte is followed by its lower byte, not a reply
        if (expect_lower)
          expect_lower = 1'b0;
        else if (data[CMD_RW_BIT - DATA_BITS])
          expect_lower = 1'b1;
        else
          send_reply();
      end
    end
  end

endmodule
